// ==== rtl/bus_arbiter.sv ====
`timescale 1ns/1ps

module bus_arbiter import mem_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n,
    input  bus_req_t lsu_req_i,
    output bus_rsp_t lsu_rsp_o,
    input  bus_req_t fetch_req_i,
    output bus_rsp_t fetch_rsp_o,
    output bus_req_t mem_req_o,
    input  bus_rsp_t mem_rsp_i
);

    typedef enum logic [1:0] {
        G_IDLE,
        G_LSU,
        G_FETCH
    } grant_e;

    grant_e grant_q;
    grant_e sel;
    logic   lsu_want;
    logic   fetch_want;
    logic   end_fire;

    assign lsu_want   = lsu_req_i.ar_valid || lsu_req_i.aw_valid;
    assign fetch_want = fetch_req_i.ar_valid;

    // ************************************************************
    // grant selection
    // ************************************************************
    // data traffic wins over instruction reads when both ask
    always_comb begin
        sel = grant_q;
        if (grant_q == G_IDLE) begin
            if (lsu_want) begin
                sel = G_LSU;
            end else if (fetch_want) begin
                sel = G_FETCH;
            end
        end
    end

    // grant released once the response handshake completes
    assign end_fire = (mem_rsp_i.r_valid && mem_req_o.r_ready) ||
                      (mem_rsp_i.b_valid && mem_req_o.b_ready);

    always_ff @(posedge clk_i) begin
        if (rst_n) begin
            grant_q <= G_IDLE;
        end else if (end_fire) begin
            grant_q <= G_IDLE;
        end else begin
            grant_q <= sel;
        end
    end

    // ************************************************************
    // request and response steering
    // ************************************************************
    always_comb begin
        mem_req_o   = '0;
        lsu_rsp_o   = '0;
        fetch_rsp_o = '0;
        case (sel)
            G_LSU: begin
                mem_req_o = lsu_req_i;
                lsu_rsp_o = mem_rsp_i;
            end
            G_FETCH: begin
                mem_req_o   = fetch_req_i;
                fetch_rsp_o = mem_rsp_i;
            end
            default: begin
                mem_req_o = '0;
            end
        endcase
    end

    // fetch side never writes
    a_fetch_no_write: assert property (@(posedge clk_i) disable iff (rst_n)
        (sel == G_FETCH) |-> !mem_req_o.aw_valid);

endmodule

// ==== rtl/fetch_unit.sv ====
`timescale 1ns/1ps

module fetch_unit import mem_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n,
    input  logic     fetch_valid_i,
    input  addr_t    fetch_pc_i,
    output logic     fetch_ready_o,
    output logic     fetch_done_o,
    output inst_t    fetch_inst_o,
    output bus_req_t bus_req_o,
    input  bus_rsp_t bus_rsp_i
);

    typedef enum logic [1:0] {
        F_IDLE,
        F_ADDR,
        F_DATA
    } fetch_state_e;

    fetch_state_e state_q;
    addr_t        pc_q;
    logic         r_fire;

    assign r_fire        = (state_q == F_DATA) && bus_rsp_i.r_valid;
    assign fetch_ready_o = (state_q == F_IDLE);

    always_ff @(posedge clk_i) begin
        if (rst_n) begin
            state_q      <= F_IDLE;
            fetch_done_o <= 1'b0;
        end else begin
            fetch_done_o <= r_fire;
            case (state_q)
                F_IDLE:  if (fetch_valid_i) state_q <= F_ADDR;
                F_ADDR:  if (bus_rsp_i.ar_ready) state_q <= F_DATA;
                F_DATA:  if (bus_rsp_i.r_valid) state_q <= F_IDLE;
                default: state_q <= F_IDLE;
            endcase
        end
    end

    // pc and the selected instruction half
    always_ff @(posedge clk_i) begin
        if (fetch_valid_i && fetch_ready_o) begin
            pc_q <= fetch_pc_i;
        end
        if (r_fire) begin
            fetch_inst_o <= pc_q[2] ? bus_rsp_i.r_data[DATA_W-1:INST_W]
                                    : bus_rsp_i.r_data[INST_W-1:0];
        end
    end

    // read only master, write channels stay quiet
    always_comb begin
        bus_req_o          = '0;
        bus_req_o.ar_valid = (state_q == F_ADDR);
        bus_req_o.ar_addr  = {pc_q[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
        bus_req_o.r_ready  = (state_q == F_DATA);
    end

    a_pc_aligned: assert property (@(posedge clk_i) disable iff (rst_n)
        (state_q != F_IDLE) |-> (pc_q[1:0] == 2'b00));

endmodule

// ==== rtl/load_store_unit.sv ====
`timescale 1ns/1ps

module load_store_unit import mem_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n,
    input  lsu_req_t lsu_req_i,
    output logic     lsu_ready_o,
    output logic     lsu_done_o,
    output data_t    lsu_rdata_o,
    output bus_req_t bus_req_o,
    input  bus_rsp_t bus_rsp_i
);

    typedef enum logic [1:0] {
        L_IDLE,
        L_ADDR,
        L_RESP
    } lsu_state_e;

    lsu_state_e       state_q;
    lsu_req_t         req_q;
    logic             addr_fire;
    logic             resp_fire;
    logic [OFF_W-1:0] off;
    logic [OFF_W-1:0] align_mask;
    strb_t            size_strb;
    data_t            rshift;
    data_t            rdata_ext;
    logic             sext;

    assign lsu_ready_o = (state_q == L_IDLE);
    assign off         = req_q.addr[OFF_W-1:0];

    // aw and w complete together, the slave raises both readies at once
    assign addr_fire = (state_q == L_ADDR) &&
                       (req_q.write ? (bus_rsp_i.aw_ready && bus_rsp_i.w_ready)
                                    : bus_rsp_i.ar_ready);
    assign resp_fire = (state_q == L_RESP) &&
                       (req_q.write ? bus_rsp_i.b_valid : bus_rsp_i.r_valid);

    always_ff @(posedge clk_i) begin
        if (rst_n) begin
            state_q    <= L_IDLE;
            lsu_done_o <= 1'b0;
        end else begin
            lsu_done_o <= resp_fire;
            case (state_q)
                L_IDLE:  if (lsu_req_i.valid) state_q <= L_ADDR;
                L_ADDR:  if (addr_fire) state_q <= L_RESP;
                L_RESP:  if (resp_fire) state_q <= L_IDLE;
                default: state_q <= L_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (lsu_req_i.valid && lsu_ready_o) begin
            req_q <= lsu_req_i;
        end
        if (resp_fire && !req_q.write) begin
            lsu_rdata_o <= rdata_ext;
        end
    end

    // ************************************************************
    // size decode, strobes and load extension
    // ************************************************************
    always_comb begin
        case (req_q.size)
            SZ_BYTE: begin
                size_strb  = 8'h01;
                align_mask = 3'b000;
            end
            SZ_HALF: begin
                size_strb  = 8'h03;
                align_mask = 3'b001;
            end
            SZ_WORD: begin
                size_strb  = 8'h0f;
                align_mask = 3'b011;
            end
            default: begin
                size_strb  = 8'hff;
                align_mask = 3'b111;
            end
        endcase
    end

    // addressed bytes moved down to lane zero
    assign rshift = bus_rsp_i.r_data >> {off, 3'b000};

    always_comb begin
        case (req_q.size)
            SZ_BYTE: begin
                sext      = !req_q.is_unsigned && rshift[7];
                rdata_ext = {{(DATA_W-8){sext}}, rshift[7:0]};
            end
            SZ_HALF: begin
                sext      = !req_q.is_unsigned && rshift[15];
                rdata_ext = {{(DATA_W-16){sext}}, rshift[15:0]};
            end
            SZ_WORD: begin
                sext      = !req_q.is_unsigned && rshift[31];
                rdata_ext = {{(DATA_W-32){sext}}, rshift[31:0]};
            end
            default: begin
                sext      = 1'b0;
                rdata_ext = rshift;
            end
        endcase
    end

    always_comb begin
        bus_req_o          = '0;
        bus_req_o.ar_valid = (state_q == L_ADDR) && !req_q.write;
        bus_req_o.ar_addr  = {req_q.addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
        bus_req_o.aw_valid = (state_q == L_ADDR) && req_q.write;
        bus_req_o.aw_addr  = {req_q.addr[ADDR_W-1:OFF_W], {OFF_W{1'b0}}};
        bus_req_o.w_valid  = (state_q == L_ADDR) && req_q.write;
        // store data shifted into its byte lanes
        bus_req_o.w_data   = req_q.wdata << {off, 3'b000};
        bus_req_o.w_strb   = size_strb << off;
        bus_req_o.r_ready  = (state_q == L_RESP) && !req_q.write;
        bus_req_o.b_ready  = (state_q == L_RESP) && req_q.write;
    end

    a_addr_aligned: assert property (@(posedge clk_i) disable iff (rst_n)
        (state_q != L_IDLE) |-> ((off & align_mask) == '0));

endmodule

// ==== rtl/mem_pkg.sv ====
package mem_pkg;

    // ************************************************************
    // bus and memory geometry
    // ************************************************************
    localparam int ADDR_W    = 32;
    localparam int DATA_W    = 64;
    localparam int STRB_W    = 8;
    localparam int INST_W    = 32;
    localparam int MEM_DEPTH = 256;

    // byte offset inside a bus word, and sram word index width
    localparam int OFF_W = $clog2(STRB_W);
    localparam int IDX_W = $clog2(MEM_DEPTH);

    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [INST_W-1:0] inst_t;
    typedef logic [1:0]        resp_t;

    localparam resp_t RESP_OKAY = 2'b00;

    typedef enum logic [1:0] {
        SZ_BYTE  = 2'd0,
        SZ_HALF  = 2'd1,
        SZ_WORD  = 2'd2,
        SZ_DWORD = 2'd3
    } mem_size_e;

    // load/store request, store value sits in the low bytes of wdata
    typedef struct packed {
        logic      valid;
        logic      write;
        logic      is_unsigned;
        mem_size_e size;
        addr_t     addr;
        data_t     wdata;
    } lsu_req_t;

    // ************************************************************
    // valid/ready bus, master and slave halves
    // ************************************************************
    typedef struct packed {
        logic  ar_valid;
        addr_t ar_addr;
        logic  aw_valid;
        addr_t aw_addr;
        logic  w_valid;
        data_t w_data;
        strb_t w_strb;
        logic  r_ready;
        logic  b_ready;
    } bus_req_t;

    typedef struct packed {
        logic  ar_ready;
        logic  aw_ready;
        logic  w_ready;
        logic  r_valid;
        data_t r_data;
        resp_t r_resp;
        logic  b_valid;
        resp_t b_resp;
    } bus_rsp_t;

endpackage

// ==== rtl/mem_subsys_top.sv ====
`timescale 1ns/1ps

module mem_subsys_top import mem_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n,
    input  logic     fetch_valid_i,
    input  addr_t    fetch_pc_i,
    output logic     fetch_ready_o,
    output logic     fetch_done_o,
    output inst_t    fetch_inst_o,
    input  lsu_req_t lsu_req_i,
    output logic     lsu_ready_o,
    output logic     lsu_done_o,
    output data_t    lsu_rdata_o
);

    // peer buses into the arbiter, and the shared sram bus
    bus_req_t fetch_bus_req;
    bus_rsp_t fetch_bus_rsp;
    bus_req_t lsu_bus_req;
    bus_rsp_t lsu_bus_rsp;
    bus_req_t mem_bus_req;
    bus_rsp_t mem_bus_rsp;

    fetch_unit u_fetch (
        .clk_i         (clk_i),
        .rst_n         (rst_n),
        .fetch_valid_i (fetch_valid_i),
        .fetch_pc_i    (fetch_pc_i),
        .fetch_ready_o (fetch_ready_o),
        .fetch_done_o  (fetch_done_o),
        .fetch_inst_o  (fetch_inst_o),
        .bus_req_o     (fetch_bus_req),
        .bus_rsp_i     (fetch_bus_rsp)
    );

    load_store_unit u_lsu (
        .clk_i       (clk_i),
        .rst_n       (rst_n),
        .lsu_req_i   (lsu_req_i),
        .lsu_ready_o (lsu_ready_o),
        .lsu_done_o  (lsu_done_o),
        .lsu_rdata_o (lsu_rdata_o),
        .bus_req_o   (lsu_bus_req),
        .bus_rsp_i   (lsu_bus_rsp)
    );

    bus_arbiter u_arbiter (
        .clk_i       (clk_i),
        .rst_n       (rst_n),
        .lsu_req_i   (lsu_bus_req),
        .lsu_rsp_o   (lsu_bus_rsp),
        .fetch_req_i (fetch_bus_req),
        .fetch_rsp_o (fetch_bus_rsp),
        .mem_req_o   (mem_bus_req),
        .mem_rsp_i   (mem_bus_rsp)
    );

    sram_bus u_sram (
        .clk_i     (clk_i),
        .rst_n     (rst_n),
        .bus_req_i (mem_bus_req),
        .bus_rsp_o (mem_bus_rsp)
    );

endmodule

// ==== rtl/sram_bus.sv ====
`timescale 1ns/1ps

module sram_bus import mem_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_n,
    input  bus_req_t bus_req_i,
    output bus_rsp_t bus_rsp_o
);

    data_t            mem [MEM_DEPTH];
    logic             r_valid_q;
    logic             b_valid_q;
    data_t            r_data_q;
    logic             busy;
    logic             rd_fire;
    logic             wr_fire;
    logic [IDX_W-1:0] rd_idx;
    logic [IDX_W-1:0] wr_idx;

    // one transfer outstanding at a time
    assign busy    = r_valid_q || b_valid_q;
    assign rd_fire = bus_req_i.ar_valid && !busy;
    assign wr_fire = bus_req_i.aw_valid && bus_req_i.w_valid && !busy;

    // word index, upper address bits ignored
    assign rd_idx = bus_req_i.ar_addr[OFF_W +: IDX_W];
    assign wr_idx = bus_req_i.aw_addr[OFF_W +: IDX_W];

    always_ff @(posedge clk_i) begin
        if (rst_n) begin
            r_valid_q <= 1'b0;
            b_valid_q <= 1'b0;
        end else begin
            if (rd_fire) begin
                r_valid_q <= 1'b1;
            end else if (bus_req_i.r_ready) begin
                r_valid_q <= 1'b0;
            end
            if (wr_fire) begin
                b_valid_q <= 1'b1;
            end else if (bus_req_i.b_ready) begin
                b_valid_q <= 1'b0;
            end
        end
    end

    // ************************************************************
    // storage array
    // ************************************************************
    always_ff @(posedge clk_i) begin
        if (wr_fire) begin
            for (int i = 0; i < STRB_W; i++) begin
                if (bus_req_i.w_strb[i]) begin
                    mem[wr_idx][8*i +: 8] <= bus_req_i.w_data[8*i +: 8];
                end
            end
        end
        if (rd_fire) begin
            r_data_q <= mem[rd_idx];
        end
    end

    always_comb begin
        bus_rsp_o          = '0;
        bus_rsp_o.ar_ready = !busy;
        bus_rsp_o.aw_ready = !busy;
        bus_rsp_o.w_ready  = !busy;
        bus_rsp_o.r_valid  = r_valid_q;
        bus_rsp_o.r_data   = r_data_q;
        bus_rsp_o.r_resp   = RESP_OKAY;
        bus_rsp_o.b_valid  = b_valid_q;
        bus_rsp_o.b_resp   = RESP_OKAY;
    end

    // a master raising ar and aw together would break this
    a_one_resp: assert property (@(posedge clk_i) disable iff (rst_n)
        !(r_valid_q && b_valid_q));

endmodule

// ==== run.sh ====
#!/usr/bin/env bash
set -e
set -o pipefail

cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_top -f sim.f -o tb_top_sim

./obj_dir/tb_top_sim | tee sim.log

if grep -q "=== FAIL ===" sim.log; then
    echo "simulation reported a failure"
    exit 1
fi
echo "simulation finished without failure"

// ==== sim.f ====
rtl/mem_pkg.sv
rtl/fetch_unit.sv
rtl/load_store_unit.sv
rtl/bus_arbiter.sv
rtl/sram_bus.sv
rtl/mem_subsys_top.sv
sim/tb_clkgen.sv
sim/tb_checker.sv
sim/tb_top.sv

// ==== sim/tb_checker.sv ====
`timescale 1ns/1ps

module tb_checker import mem_pkg::*; (
    input  logic  clk_i,
    input  logic  rst_n,
    input  logic  idle_check_i,
    input  logic  fetch_ready_i,
    input  logic  fetch_done_i,
    input  inst_t fetch_inst_i,
    input  logic  lsu_ready_i,
    input  logic  lsu_done_i,
    input  data_t lsu_rdata_i,
    input  logic  fetch_push_i,
    input  inst_t fetch_exp_i,
    input  logic  lsu_push_i,
    input  logic  lsu_load_i,
    input  data_t lsu_exp_i,
    output int    checks_o,
    output int    errors_o,
    output int    pending_o
);

    // expected results per port, oldest at the front
    inst_t           fetch_q [$];
    logic [DATA_W:0] lsu_q [$];
    int              n_checks = 0;
    int              n_errors = 0;
    int              n_pending = 0;

    assign checks_o  = n_checks;
    assign errors_o  = n_errors;
    assign pending_o = n_pending;

    // sampled on the falling edge, away from the driving edge
    always @(negedge clk_i) begin : compare
        inst_t           exp_inst;
        logic [DATA_W:0] exp_lsu;
        if (!rst_n) begin
            if (fetch_done_i) begin
                if (fetch_q.size() == 0) begin
                    $display("fetch done at %0t with no fetch outstanding", $time);
                    n_errors++;
                end else begin
                    exp_inst = fetch_q.pop_front();
                    n_checks++;
                    if (fetch_inst_i !== exp_inst) begin
                        $display("ERROR %0t: fetch returned %h, expected %h",
                                 $time, fetch_inst_i, exp_inst);
                        n_errors++;
                    end
                end
            end
            if (lsu_done_i) begin
                if (lsu_q.size() == 0) begin
                    $display("load/store done at %0t with no request outstanding", $time);
                    n_errors++;
                end else begin
                    exp_lsu = lsu_q.pop_front();
                    n_checks++;
                    // top bit marks a load, stores only need to complete in order
                    if (exp_lsu[DATA_W] && (lsu_rdata_i !== exp_lsu[DATA_W-1:0])) begin
                        $display("ERROR %0t: load returned %h, expected %h",
                                 $time, lsu_rdata_i, exp_lsu[DATA_W-1:0]);
                        n_errors++;
                    end
                end
            end
            if (idle_check_i) begin
                n_checks++;
                if (!fetch_ready_i || !lsu_ready_i) begin
                    $display("ERROR %0t: ready low while idle, fetch %b lsu %b",
                             $time, fetch_ready_i, lsu_ready_i);
                    n_errors++;
                end
            end
            if (fetch_push_i) begin
                fetch_q.push_back(fetch_exp_i);
            end
            if (lsu_push_i) begin
                lsu_q.push_back({lsu_load_i, lsu_exp_i});
            end
        end
        n_pending = fetch_q.size() + lsu_q.size();
    end

endmodule

// ==== sim/tb_clkgen.sv ====
`timescale 1ns/1ps

module tb_clkgen (
    output logic clk_o
);

    // 4 ns period, rising edges at 2, 6, 10 ...
    initial begin
        clk_o = 1'b0;
    end

    always #2 clk_o = ~clk_o;

endmodule

// ==== sim/tb_top.sv ====
`timescale 1ns/1ps

module tb_top import mem_pkg::*; ();

    localparam int N_DWORD     = MEM_DEPTH;
    localparam int N_MIXED     = 96;
    localparam int N_FETCH     = 128;
    localparam int N_ROUNDS    = 200;
    localparam int TOTAL_REQ   = 2 * N_DWORD + 3 * N_MIXED + N_FETCH + 2 * N_ROUNDS;
    // 20 cycles per request, plus reset and the idle test
    localparam int CYCLE_LIMIT = 20 * TOTAL_REQ + 64;

    logic     clk_i;
    logic     rst_n;
    logic     fetch_valid_i;
    addr_t    fetch_pc_i;
    logic     fetch_ready_o;
    logic     fetch_done_o;
    inst_t    fetch_inst_o;
    lsu_req_t lsu_req_i;
    logic     lsu_ready_o;
    logic     lsu_done_o;
    data_t    lsu_rdata_o;

    // expected values handed to the checker
    logic  idle_check;
    logic  fetch_push;
    inst_t fetch_exp;
    logic  lsu_push;
    logic  lsu_push_load;
    data_t lsu_exp;
    int    checks;
    int    errors;
    int    pending;

    data_t       model_mem [MEM_DEPTH];
    logic [31:0] lcg_state;
    int          cycle_cnt = 0;
    int          err_base;
    int          tests_failed;

    tb_clkgen u_clkgen (
        .clk_o (clk_i)
    );

    mem_subsys_top DUT (
        .clk_i         (clk_i),
        .rst_n         (rst_n),
        .fetch_valid_i (fetch_valid_i),
        .fetch_pc_i    (fetch_pc_i),
        .fetch_ready_o (fetch_ready_o),
        .fetch_done_o  (fetch_done_o),
        .fetch_inst_o  (fetch_inst_o),
        .lsu_req_i     (lsu_req_i),
        .lsu_ready_o   (lsu_ready_o),
        .lsu_done_o    (lsu_done_o),
        .lsu_rdata_o   (lsu_rdata_o)
    );

    tb_checker u_checker (
        .clk_i         (clk_i),
        .rst_n         (rst_n),
        .idle_check_i  (idle_check),
        .fetch_ready_i (fetch_ready_o),
        .fetch_done_i  (fetch_done_o),
        .fetch_inst_i  (fetch_inst_o),
        .lsu_ready_i   (lsu_ready_o),
        .lsu_done_i    (lsu_done_o),
        .lsu_rdata_i   (lsu_rdata_o),
        .fetch_push_i  (fetch_push),
        .fetch_exp_i   (fetch_exp),
        .lsu_push_i    (lsu_push),
        .lsu_load_i    (lsu_push_load),
        .lsu_exp_i     (lsu_exp),
        .checks_o      (checks),
        .errors_o      (errors),
        .pending_o     (pending)
    );

    always @(posedge clk_i) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= CYCLE_LIMIT) begin
            $display("simulation hung, no finish after %0d cycles", cycle_cnt);
            $display("=== FAIL ===");
            $finish;
        end
    end

    // ************************************************************
    // random numbers and the reference memory
    // ************************************************************
    function automatic logic [31:0] lcg_next();
        lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
        // fold high bits down, the low LCG bits cycle quickly
        return lcg_state ^ (lcg_state >> 15);
    endfunction

    function automatic data_t rand_data();
        return {lcg_next(), lcg_next()};
    endfunction

    function automatic int size_bytes(input mem_size_e size);
        return 1 << int'(size);
    endfunction

    function automatic mem_size_e pick_size(input logic [31:0] r);
        mem_size_e size;
        case (r % 32'd3)
            32'd0:   size = SZ_BYTE;
            32'd1:   size = SZ_HALF;
            default: size = SZ_WORD;
        endcase
        return size;
    endfunction

    // natural alignment inside the 2 KiB sram window
    function automatic addr_t align_addr(input logic [31:0] r, input mem_size_e size);
        addr_t mask;
        mask = addr_t'(size_bytes(size) - 1);
        return (r & 32'h0000_07ff) & ~mask;
    endfunction

    task automatic model_store(input addr_t addr, input mem_size_e size, input data_t wdata);
        int off;
        off = int'(addr[2:0]);
        for (int i = 0; i < size_bytes(size); i++) begin
            model_mem[addr[10:3]][8*(off+i) +: 8] = wdata[8*i +: 8];
        end
    endtask

    function automatic data_t load_expect(input addr_t addr, input mem_size_e size,
                                          input logic uns);
        data_t word;
        data_t val;
        int    off;
        int    nbytes;
        word   = model_mem[addr[10:3]];
        off    = int'(addr[2:0]);
        nbytes = size_bytes(size);
        val    = '0;
        for (int i = 0; i < nbytes; i++) begin
            val[8*i +: 8] = word[8*(off+i) +: 8];
        end
        if (!uns && size != SZ_DWORD && val[8*nbytes-1]) begin
            val = val | ~((64'd1 << (8 * nbytes)) - 64'd1);
        end
        return val;
    endfunction

    function automatic inst_t fetch_expect(input addr_t pc);
        data_t word;
        word = model_mem[pc[10:3]];
        return pc[2] ? word[63:32] : word[31:0];
    endfunction

    // ************************************************************
    // request driving
    // ************************************************************
    task automatic issue_lsu(input logic write, input logic uns, input mem_size_e size,
                             input addr_t addr, input data_t wdata);
        if (write) begin
            model_store(addr, size, wdata);
        end
        lsu_req_i.valid       = 1'b1;
        lsu_req_i.write       = write;
        lsu_req_i.is_unsigned = uns;
        lsu_req_i.size        = size;
        lsu_req_i.addr        = addr;
        lsu_req_i.wdata       = wdata;
        lsu_push              = 1'b1;
        lsu_push_load         = !write;
        lsu_exp               = write ? '0 : load_expect(addr, size, uns);
    endtask

    task automatic issue_fetch(input addr_t pc);
        fetch_valid_i = 1'b1;
        fetch_pc_i    = pc;
        fetch_push    = 1'b1;
        fetch_exp     = fetch_expect(pc);
    endtask

    // strobes last one cycle
    task automatic advance();
        @(posedge clk_i);
        #1;
        fetch_valid_i   = 1'b0;
        lsu_req_i.valid = 1'b0;
        fetch_push      = 1'b0;
        lsu_push        = 1'b0;
    endtask

    task automatic wait_done(input logic want_fetch, input logic want_lsu);
        logic got_fetch;
        logic got_lsu;
        got_fetch = !want_fetch;
        got_lsu   = !want_lsu;
        while (!got_fetch || !got_lsu) begin
            @(posedge clk_i);
            #1;
            if (fetch_done_o) begin
                got_fetch = 1'b1;
            end
            if (lsu_done_o) begin
                got_lsu = 1'b1;
            end
        end
    endtask

    task automatic lsu_step(input logic write, input logic uns, input mem_size_e size,
                            input addr_t addr, input data_t wdata);
        issue_lsu(write, uns, size, addr, wdata);
        advance();
        wait_done(1'b0, 1'b1);
    endtask

    task automatic finish_test(input string name);
        int errs;
        // let the checker see the last done pulse
        repeat (2) @(posedge clk_i);
        #1;
        errs     = errors - err_base;
        err_base = errors;
        if (errs != 0) begin
            tests_failed++;
        end
        $display("%-24s %s, %0d errors", name, (errs == 0) ? "ok" : "failed", errs);
    endtask

    initial begin
        addr_t       addr;
        logic [31:0] r;
        mem_size_e   sz;
        lcg_state     = 32'h8bc1;
        rst_n         = 1'b1;
        fetch_valid_i = 1'b0;
        fetch_pc_i    = '0;
        lsu_req_i     = '0;
        idle_check    = 1'b0;
        fetch_push    = 1'b0;
        fetch_exp     = '0;
        lsu_push      = 1'b0;
        lsu_push_load = 1'b0;
        lsu_exp       = '0;
        tests_failed  = 0;
        repeat (4) @(posedge clk_i);
        #1;
        rst_n    = 1'b0;
        err_base = errors;

        // quiet after reset, readies up and no done
        idle_check = 1'b1;
        repeat (8) @(posedge clk_i);
        #1;
        idle_check = 1'b0;
        finish_test("reset state");

        for (int i = 0; i < N_DWORD; i++) begin
            lsu_step(1'b1, 1'b0, SZ_DWORD, addr_t'(8 * i), rand_data());
        end
        for (int i = 0; i < N_DWORD; i++) begin
            lsu_step(1'b0, 1'b0, SZ_DWORD, addr_t'(8 * i), '0);
        end
        finish_test("dword fill and read");

        for (int i = 0; i < N_MIXED; i++) begin
            sz   = pick_size(lcg_next());
            addr = align_addr(lcg_next(), sz);
            lsu_step(1'b1, 1'b0, sz, addr, rand_data());
            // whole word back, neighbour bytes must be untouched
            lsu_step(1'b0, 1'b0, SZ_DWORD, align_addr(addr, SZ_DWORD), '0);
            r    = lcg_next();
            sz   = pick_size(r);
            addr = align_addr(lcg_next(), sz);
            lsu_step(1'b0, r[8], sz, addr, '0);
        end
        finish_test("sub-word store and load");

        for (int i = 0; i < N_FETCH; i++) begin
            issue_fetch(align_addr(lcg_next(), SZ_WORD));
            advance();
            wait_done(1'b1, 1'b0);
        end
        finish_test("fetch");

        // both peers in one cycle, small window so stores hit fetched words
        for (int i = 0; i < N_ROUNDS; i++) begin
            r    = lcg_next();
            sz   = mem_size_e'(r[1:0]);
            addr = align_addr(lcg_next() & 32'h0000_00ff, sz);
            issue_lsu(r[9], r[10], sz, addr, rand_data());
            issue_fetch(align_addr(lcg_next() & 32'h0000_00ff, SZ_WORD));
            advance();
            wait_done(1'b1, 1'b1);
        end
        finish_test("concurrent peers");

        $display("tests 5, failed %0d, checks %0d, errors %0d, pending %0d",
                 tests_failed, checks, errors, pending);
        if (pending != 0) begin
            $display("%0d requests never completed by the end of the run", pending);
        end
        if (errors == 0 && pending == 0) begin
            $display("=== PASS ===");
        end else begin
            $display("=== FAIL ===");
        end
        $finish;
    end

endmodule
